// File: rtl/axi_settings.svh
// AXI read crossbar settings

`ifndef AXI_SETTINGS_SVH
`define AXI_SETTINGS_SVH

// ---------------------------------------------------------------------------
// Channel widths
// ---------------------------------------------------------------------------
`define AXI_ID_BITS     4       // Master side ID
`define AXI_IDS_BITS    8       // Slave side ID, master ID plus tag
`define AXI_ADDR_BITS   32
`define AXI_DATA_BITS   32
`define AXI_LEN_BITS    4       // Beats minus one
`define AXI_SIZE_BITS   3
`define AXI_BURST_BITS  2

// Master index lands here in the slave ID
`define AXI_TAG_BIT     4

// ---------------------------------------------------------------------------
// Address map
// ---------------------------------------------------------------------------
// Only one 64 KB region is decoded at all
`define MAP_REGION_HI   16'h0000

// Slave select sits right below the region field
`define MAP_SEL_BITS    2

`endif

// File: rtl/axi_pkg.sv
// AXI read channel types
`include "axi_settings.svh"

package axi_pkg;

	// Read response codes
	typedef enum logic [1:0] {
		OKAY   = 2'b00,
		SLVERR = 2'b10,
		DECERR = 2'b11   // No slave at this address
	} resp_e;

	// ---------------------------------------------------------------------------
	// AR payloads
	// ---------------------------------------------------------------------------
	typedef struct packed {
		logic [`AXI_ID_BITS-1:0]    id;     // Master ID
		logic [`AXI_ADDR_BITS-1:0]  addr;
		logic [`AXI_LEN_BITS-1:0]   len;    // Beats minus one
		logic [`AXI_SIZE_BITS-1:0]  size;
		logic [`AXI_BURST_BITS-1:0] burst;
	} ar_chan_t;

	// Slave side, ID carries the master tag
	typedef struct packed {
		logic [`AXI_IDS_BITS-1:0]   id;
		logic [`AXI_ADDR_BITS-1:0]  addr;
		logic [`AXI_LEN_BITS-1:0]   len;
		logic [`AXI_SIZE_BITS-1:0]  size;
		logic [`AXI_BURST_BITS-1:0] burst;
	} ars_chan_t;

	// ---------------------------------------------------------------------------
	// R payloads
	// ---------------------------------------------------------------------------
	typedef struct packed {
		logic [`AXI_ID_BITS-1:0]   id;
		logic [`AXI_DATA_BITS-1:0] data;
		resp_e                     resp;
		logic                      last;  // Final beat of burst
	} r_chan_t;

	typedef struct packed {
		logic [`AXI_IDS_BITS-1:0]  id;    // Still tagged
		logic [`AXI_DATA_BITS-1:0] data;
		resp_e                     resp;
		logic                      last;
	} rs_chan_t;

endpackage

// File: rtl/xbar_map_pkg.sv
// Crossbar address map types
`include "axi_settings.svh"

package xbar_map_pkg;

	// Decoded view of a read address
	typedef struct packed {
		logic [15:0]                                   region;  // Must match map
		logic [`MAP_SEL_BITS-1:0]                      sel;     // Slave index
		logic [`AXI_ADDR_BITS-17-`MAP_SEL_BITS:0]      offset;  // Within slave
	} addr_fields_t;

	typedef union packed {
		logic [`AXI_ADDR_BITS-1:0] word;  // Raw address
		addr_fields_t              f;
	} addr_u;

	typedef enum logic [1:0] {
		TGT_S0  = 2'd0,
		TGT_S1  = 2'd1,
		TGT_ERR = 2'd2   // Answered inside the crossbar
	} target_e;

	// Burst in flight
	typedef struct packed {
		logic                     master;  // Granted master index
		target_e                  target;
		logic [`AXI_LEN_BITS-1:0] len;
		logic [`AXI_ID_BITS-1:0]  id;      // Needed for DECERR beats
	} route_t;

endpackage

// File: rtl/ar_arbiter.sv
// Round-robin AR arbiter

module ar_arbiter (
	input  logic ACLK,
	input  logic ARESETn,
	input  logic m0_req,       // Master 0 ar_valid
	input  logic m1_req,       // Master 1 ar_valid
	input  logic burst_start,  // AR handshake done
	input  logic burst_done,   // Last R beat accepted
	output logic grant,        // Master index
	output logic grant_valid
);

	typedef enum logic [1:0] {
		IDLE,   // Grant follows requests
		WAIT,   // AR offered, slave not ready yet
		BUSY    // Burst in flight
	} state_e;

	state_e state;
	logic   held_grant;    // Grant frozen while not idle
	logic   last_served;   // Loser of the next tie
	logic   arb_grant;     // Fresh decision

	// ---------------------------------------------------------------------------
	// Fresh decision, only used while idle
	// ---------------------------------------------------------------------------
	always_comb begin
		if (m0_req && m1_req)
			arb_grant = ~last_served;   // Tie, alternate
		else
			arb_grant = m1_req;         // Only requester, or 0 when none
	end

	assign grant       = (state == IDLE) ? arb_grant : held_grant;
	assign grant_valid = (state != IDLE) || m0_req || m1_req;

	// ---------------------------------------------------------------------------
	// Hold the grant until the burst ends
	// ---------------------------------------------------------------------------
	always_ff @(posedge ACLK or negedge ARESETn) begin
		if (!ARESETn) begin
			state       <= IDLE;
			held_grant  <= 1'b0;
			last_served <= 1'b0;   // Master 1 wins first tie
		end else begin
			case (state)
				IDLE: begin
					if (m0_req || m1_req) begin
						held_grant <= arb_grant;
						state      <= burst_start ? BUSY : WAIT;
					end
				end
				WAIT: begin
					// Master keeps ar_valid up, so no way back to idle
					if (burst_start)
						state <= BUSY;
				end
				BUSY: begin
					if (burst_done) begin
						last_served <= held_grant;
						state       <= IDLE;
					end
				end
				default: state <= IDLE;
			endcase
		end
	end

endmodule

// File: rtl/ar_router.sv
// AR decode and steering
`include "axi_settings.svh"

module ar_router (
	input  logic                    ACLK,
	input  logic                    ARESETn,
	input  axi_pkg::ar_chan_t       m0_ar,
	input  axi_pkg::ar_chan_t       m1_ar,
	input  logic                    m0_ar_valid,
	input  logic                    m1_ar_valid,
	output logic                    m0_ar_ready,
	output logic                    m1_ar_ready,
	output axi_pkg::ars_chan_t      s0_ar,
	output axi_pkg::ars_chan_t      s1_ar,
	output logic                    s0_ar_valid,
	output logic                    s1_ar_valid,
	input  logic                    s0_ar_ready,
	input  logic                    s1_ar_ready,
	input  logic                    grant,
	input  logic                    grant_valid,
	input  logic                    burst_done,
	output logic                    burst_start,
	output xbar_map_pkg::route_t    route,
	output logic                    route_valid
);

	axi_pkg::ar_chan_t        sel_ar;      // Granted master's command
	logic                     sel_valid;
	xbar_map_pkg::addr_u      sel_addr;
	xbar_map_pkg::target_e    target;
	axi_pkg::ars_chan_t       slave_ar;    // Command with tagged ID
	logic [`AXI_IDS_BITS-1:0] sid;
	logic                     sel_ready;
	logic                     fwd;         // Command goes out this cycle

	// ---------------------------------------------------------------------------
	// Select and decode
	// ---------------------------------------------------------------------------
	always_comb begin
		sel_ar        = grant ? m1_ar : m0_ar;
		sel_valid     = grant ? m1_ar_valid : m0_ar_valid;
		sel_addr.word = sel_ar.addr;
		if (sel_addr.f.region != `MAP_REGION_HI)
			target = xbar_map_pkg::TGT_ERR;
		else if (sel_addr.f.sel == 0)
			target = xbar_map_pkg::TGT_S0;
		else if (sel_addr.f.sel == 1)
			target = xbar_map_pkg::TGT_S1;
		else
			target = xbar_map_pkg::TGT_ERR;   // Select 2 and 3 unmapped
	end

	// Tag keeps the master index for the slave
	always_comb begin
		sid                     = '0;
		sid[`AXI_ID_BITS-1:0]   = sel_ar.id;
		sid[`AXI_TAG_BIT]       = grant;
		slave_ar.id             = sid;
		slave_ar.addr           = sel_ar.addr;
		slave_ar.len            = sel_ar.len;
		slave_ar.size           = sel_ar.size;
		slave_ar.burst          = sel_ar.burst;
	end

	assign fwd = grant_valid && sel_valid && !route_valid;   // One burst at a time

	// ---------------------------------------------------------------------------
	// Steering, unmapped commands accepted here
	// ---------------------------------------------------------------------------
	always_comb begin
		s0_ar       = '0;
		s1_ar       = '0;
		s0_ar_valid = 1'b0;
		s1_ar_valid = 1'b0;
		sel_ready   = 1'b1;              // DECERR path is always ready
		case (target)
			xbar_map_pkg::TGT_S0: begin
				s0_ar       = fwd ? slave_ar : '0;
				s0_ar_valid = fwd;
				sel_ready   = s0_ar_ready;
			end
			xbar_map_pkg::TGT_S1: begin
				s1_ar       = fwd ? slave_ar : '0;
				s1_ar_valid = fwd;
				sel_ready   = s1_ar_ready;
			end
			default: ;
		endcase
	end

	assign m0_ar_ready = fwd && !grant && sel_ready;
	assign m1_ar_ready = fwd && grant && sel_ready;
	assign burst_start = fwd && sel_ready;      // AR handshake

	// ---------------------------------------------------------------------------
	// Route capture
	// ---------------------------------------------------------------------------
	always_ff @(posedge ACLK or negedge ARESETn) begin
		if (!ARESETn)
			route_valid <= 1'b0;
		else if (burst_start)
			route_valid <= 1'b1;
		else if (burst_done)
			route_valid <= 1'b0;   // Next grant one cycle later
	end

	always_ff @(posedge ACLK) begin
		if (burst_start) begin
			route.master <= grant;
			route.target <= target;
			route.len    <= sel_ar.len;
			route.id     <= sel_ar.id;
		end
	end

endmodule

// File: rtl/r_return.sv
// R beat return path
`include "axi_settings.svh"

module r_return (
	input  logic                    ACLK,
	input  logic                    ARESETn,
	input  xbar_map_pkg::route_t    route,
	input  logic                    route_valid,
	input  axi_pkg::rs_chan_t       s0_r,
	input  axi_pkg::rs_chan_t       s1_r,
	input  logic                    s0_r_valid,
	input  logic                    s1_r_valid,
	output logic                    s0_r_ready,
	output logic                    s1_r_ready,
	output axi_pkg::r_chan_t        m0_r,
	output axi_pkg::r_chan_t        m1_r,
	output logic                    m0_r_valid,
	output logic                    m1_r_valid,
	input  logic                    m0_r_ready,
	input  logic                    m1_r_ready,
	output logic                    burst_done
);

	axi_pkg::r_chan_t         beat;        // Beat toward routed master
	logic                     beat_valid;
	logic                     m_ready;     // Routed master's r_ready
	logic                     is_err;
	logic [`AXI_LEN_BITS-1:0] err_cnt;     // DECERR beats sent

	assign is_err  = (route.target == xbar_map_pkg::TGT_ERR);
	assign m_ready = route.master ? m1_r_ready : m0_r_ready;

	// ---------------------------------------------------------------------------
	// Beat source
	// ---------------------------------------------------------------------------
	always_comb begin
		if (is_err) begin
			// Generated locally, one per cycle
			beat.id    = route.id;
			beat.data  = '0;
			beat.resp  = axi_pkg::DECERR;
			beat.last  = (err_cnt == route.len);
			beat_valid = route_valid;
		end else if (route.target == xbar_map_pkg::TGT_S1) begin
			beat.id    = s1_r.id[`AXI_ID_BITS-1:0];   // Drop master tag
			beat.data  = s1_r.data;
			beat.resp  = s1_r.resp;
			beat.last  = s1_r.last;
			beat_valid = route_valid && s1_r_valid;
		end else begin
			beat.id    = s0_r.id[`AXI_ID_BITS-1:0];
			beat.data  = s0_r.data;
			beat.resp  = s0_r.resp;
			beat.last  = s0_r.last;
			beat_valid = route_valid && s0_r_valid;
		end
	end

	// ---------------------------------------------------------------------------
	// Steering to master, ready passed straight back
	// ---------------------------------------------------------------------------
	assign m0_r       = route.master ? '0 : beat;
	assign m1_r       = route.master ? beat : '0;
	assign m0_r_valid = beat_valid && !route.master;
	assign m1_r_valid = beat_valid && route.master;

	assign s0_r_ready = route_valid && (route.target == xbar_map_pkg::TGT_S0) && m_ready;
	assign s1_r_ready = route_valid && (route.target == xbar_map_pkg::TGT_S1) && m_ready;

	assign burst_done = beat_valid && m_ready && beat.last;   // Last beat taken

	// DECERR beat counter
	always_ff @(posedge ACLK or negedge ARESETn) begin
		if (!ARESETn)
			err_cnt <= '0;
		else if (burst_done)
			err_cnt <= '0;           // Ready for next burst
		else if (route_valid && is_err && m_ready)
			err_cnt <= err_cnt + 1'b1;
	end

endmodule

// File: rtl/axi_read_xbar.sv
// Two by two AXI read crossbar

module axi_read_xbar (
	input  logic               ACLK,
	input  logic               ARESETn,

	// Master 0
	input  axi_pkg::ar_chan_t  m0_ar,
	input  logic               m0_ar_valid,
	output logic               m0_ar_ready,
	output axi_pkg::r_chan_t   m0_r,
	output logic               m0_r_valid,
	input  logic               m0_r_ready,

	// Master 1
	input  axi_pkg::ar_chan_t  m1_ar,
	input  logic               m1_ar_valid,
	output logic               m1_ar_ready,
	output axi_pkg::r_chan_t   m1_r,
	output logic               m1_r_valid,
	input  logic               m1_r_ready,

	// Slave 0
	output axi_pkg::ars_chan_t s0_ar,
	output logic               s0_ar_valid,
	input  logic               s0_ar_ready,
	input  axi_pkg::rs_chan_t  s0_r,
	input  logic               s0_r_valid,
	output logic               s0_r_ready,

	// Slave 1
	output axi_pkg::ars_chan_t s1_ar,
	output logic               s1_ar_valid,
	input  logic               s1_ar_ready,
	input  axi_pkg::rs_chan_t  s1_r,
	input  logic               s1_r_valid,
	output logic               s1_r_ready
);

	logic                 grant;         // Arbiter to router
	logic                 grant_valid;
	logic                 burst_start;   // Router to arbiter
	logic                 burst_done;    // Return path to both
	xbar_map_pkg::route_t route;
	logic                 route_valid;

	// ---------------------------------------------------------------------------
	// Arbitrate, route address, return data
	// ---------------------------------------------------------------------------
	ar_arbiter ar_arbiter_i (
		.ACLK        (ACLK),
		.ARESETn     (ARESETn),
		.m0_req      (m0_ar_valid),
		.m1_req      (m1_ar_valid),
		.burst_start (burst_start),
		.burst_done  (burst_done),
		.grant       (grant),
		.grant_valid (grant_valid)
	);

	ar_router ar_router_i (
		.ACLK        (ACLK),
		.ARESETn     (ARESETn),
		.m0_ar       (m0_ar),
		.m1_ar       (m1_ar),
		.m0_ar_valid (m0_ar_valid),
		.m1_ar_valid (m1_ar_valid),
		.m0_ar_ready (m0_ar_ready),
		.m1_ar_ready (m1_ar_ready),
		.s0_ar       (s0_ar),
		.s1_ar       (s1_ar),
		.s0_ar_valid (s0_ar_valid),
		.s1_ar_valid (s1_ar_valid),
		.s0_ar_ready (s0_ar_ready),
		.s1_ar_ready (s1_ar_ready),
		.grant       (grant),
		.grant_valid (grant_valid),
		.burst_done  (burst_done),
		.burst_start (burst_start),
		.route       (route),
		.route_valid (route_valid)
	);

	r_return r_return_i (
		.ACLK        (ACLK),
		.ARESETn     (ARESETn),
		.route       (route),
		.route_valid (route_valid),
		.s0_r        (s0_r),
		.s1_r        (s1_r),
		.s0_r_valid  (s0_r_valid),
		.s1_r_valid  (s1_r_valid),
		.s0_r_ready  (s0_r_ready),
		.s1_r_ready  (s1_r_ready),
		.m0_r        (m0_r),
		.m1_r        (m1_r),
		.m0_r_valid  (m0_r_valid),
		.m1_r_valid  (m1_r_valid),
		.m0_r_ready  (m0_r_ready),
		.m1_r_ready  (m1_r_ready),
		.burst_done  (burst_done)
	);

endmodule

// File: sim/axi_read_xbar_tb.sv
// AXI read crossbar testbench
`include "axi_settings.svh"

module axi_read_xbar_tb;
	timeunit 1ns;
	timeprecision 100ps;

	localparam int          MAX_REQS = 64;
	localparam int          TIMEOUT  = 400;    // Cycles per request group
	localparam logic [2:0]  AR_SIZE  = 3'd2;   // Four byte beats
	localparam logic [1:0]  AR_BURST = 2'b01;  // INCR

	// Input file line with one hex digit per small field
	typedef struct packed {
		logic [3:0]                master;
		logic [3:0]                id;
		logic [`AXI_ADDR_BITS-1:0] addr;
		logic [3:0]                len;
		logic [3:0]                tgt;    // 0 slave 0, 1 slave 1, 2 unmapped
		logic [3:0]                resp;
		logic [3:0]                pair;   // Issued with the next line
	} req_t;

	logic ACLK;
	logic ARESETn;

	axi_pkg::ar_chan_t  m_ar [2];
	logic               m_ar_valid [2];
	logic               m_ar_ready [2];
	axi_pkg::r_chan_t   m_r [2];
	logic               m_r_valid [2];
	logic               m_r_ready [2];
	axi_pkg::ars_chan_t s_ar [2];
	logic               s_ar_valid [2];
	logic               s_ar_ready [2];
	axi_pkg::rs_chan_t  s_r [2];
	logic               s_r_valid [2];
	logic               s_r_ready [2];

	logic [55:0]        req_mem [MAX_REQS];
	req_t               pend [2];         // Request per master
	logic               pend_valid [2];
	logic               last_served;      // Loser of the next tie
	int                 mismatches;
	int                 protocol_errs;
	int                 timeouts;

	axi_pkg::ars_chan_t       s_cmd [2];  // Slave model state
	logic                     s_busy [2];
	logic [`AXI_LEN_BITS-1:0] s_beat [2];

	initial begin
		ACLK = 1'b0;
		forever #4 ACLK = ~ACLK;
	end

	axi_read_xbar axi_read_xbar_i (
		.ACLK        (ACLK),
		.ARESETn     (ARESETn),
		.m0_ar       (m_ar[0]),
		.m0_ar_valid (m_ar_valid[0]),
		.m0_ar_ready (m_ar_ready[0]),
		.m0_r        (m_r[0]),
		.m0_r_valid  (m_r_valid[0]),
		.m0_r_ready  (m_r_ready[0]),
		.m1_ar       (m_ar[1]),
		.m1_ar_valid (m_ar_valid[1]),
		.m1_ar_ready (m_ar_ready[1]),
		.m1_r        (m_r[1]),
		.m1_r_valid  (m_r_valid[1]),
		.m1_r_ready  (m_r_ready[1]),
		.s0_ar       (s_ar[0]),
		.s0_ar_valid (s_ar_valid[0]),
		.s0_ar_ready (s_ar_ready[0]),
		.s0_r        (s_r[0]),
		.s0_r_valid  (s_r_valid[0]),
		.s0_r_ready  (s_r_ready[0]),
		.s1_ar       (s_ar[1]),
		.s1_ar_valid (s_ar_valid[1]),
		.s1_ar_ready (s_ar_ready[1]),
		.s1_r        (s_r[1]),
		.s1_r_valid  (s_r_valid[1]),
		.s1_r_ready  (s_r_ready[1])
	);

	// ---------------------------------------------------------------------------
	// Slave models with random ar_ready and r_valid delays
	// ---------------------------------------------------------------------------
	always @(posedge ACLK or negedge ARESETn) begin
		if (!ARESETn) begin
			for (int i = 0; i < 2; i++) begin
				s_ar_ready[i] <= 1'b0;
				s_r_valid[i]  <= 1'b0;
				s_r[i]        <= '0;
				s_busy[i]     <= 1'b0;
				s_beat[i]     <= '0;
			end
		end else begin
			for (int i = 0; i < 2; i++) begin
				if (s_ar_valid[i] && s_ar_ready[i]) begin
					s_cmd[i]      <= s_ar[i];   // Keep tagged ID
					s_busy[i]     <= 1'b1;
					s_beat[i]     <= '0;
					s_ar_ready[i] <= 1'b0;
				end else if (!s_busy[i]) begin
					s_ar_ready[i] <= ($urandom % 2) != 0;
				end
				if (s_r_valid[i] && s_r_ready[i]) begin
					s_r_valid[i] <= 1'b0;
					s_beat[i]    <= s_beat[i] + 1'b1;
					if (s_r[i].last)
						s_busy[i] <= 1'b0;   // Burst done
				end else if (s_busy[i] && !s_r_valid[i] && ($urandom % 2) != 0) begin
					s_r[i].id    <= s_cmd[i].id;
					s_r[i].data  <= s_cmd[i].addr + 4 * s_beat[i];   // Address plus beat offset
					s_r[i].resp  <= axi_pkg::OKAY;
					s_r[i].last  <= (s_beat[i] == s_cmd[i].len);
					s_r_valid[i] <= 1'b1;
				end
			end
		end
	end

	// ---------------------------------------------------------------------------
	// Checks
	// ---------------------------------------------------------------------------
	task automatic check_ar(input string name, input axi_pkg::ars_chan_t exp,
			input axi_pkg::ars_chan_t act);
		if (act !== exp) begin
			$display("ERR %0t %s expected %h actual %h", $time, name, exp, act);
			mismatches++;
		end
	endtask

	task automatic check_r(input string name, input axi_pkg::r_chan_t exp,
			input axi_pkg::r_chan_t act);
		if (act !== exp) begin
			$display("ERR %0t %s expected %h actual %h", $time, name, exp, act);
			mismatches++;
		end
	endtask

	task automatic report_fault(input string msg);
		$display("%0t: %s", $time, msg);
		protocol_errs++;
	endtask

	// Region must match and select must be 0 or 1
	function automatic logic [3:0] decode_target(input logic [`AXI_ADDR_BITS-1:0] addr);
		xbar_map_pkg::addr_u a;
		a.word = addr;
		if (a.f.region == `MAP_REGION_HI && a.f.sel < 2)
			return 4'(a.f.sel);
		return 4'd2;
	endfunction

	task automatic issue_request(input req_t r, input int line);
		int m;
		m = r.master[0];
		if (decode_target(r.addr) != r.tgt)
			report_fault($sformatf("input entry %0d target disagrees with address map", line));
		pend[m]       = r;
		pend_valid[m] = 1'b1;
		m_ar[m]       <= '{id: r.id, addr: r.addr, len: r.len, size: AR_SIZE, burst: AR_BURST};
		m_ar_valid[m] <= 1'b1;
	endtask

	// Runs until every issued request has its last beat accepted
	task automatic serve_pending();
		int                 cyc;
		logic               busy;
		int                 cur;        // Master of burst in flight
		int                 beat;
		int                 want;       // Master expected to win AR
		axi_pkg::ars_chan_t exp_ar;
		axi_pkg::r_chan_t   exp_r;
		cyc  = 0;
		busy = 1'b0;
		cur  = 0;
		beat = 0;
		while ((pend_valid[0] || pend_valid[1] || busy) && cyc < TIMEOUT) begin
			@(posedge ACLK);
			cyc++;
			want = (pend_valid[0] && pend_valid[1]) ? !last_served : pend_valid[1];
			// Slave AR only for the expected request, never under a burst
			for (int k = 0; k < 2; k++) begin
				if (s_ar_valid[k] && (busy || !pend_valid[want] || pend[want].tgt != k))
					report_fault($sformatf("slave %0d saw ar_valid out of turn", k));
			end
			for (int m = 0; m < 2; m++) begin
				if (m_ar_valid[m] && m_ar_ready[m]) begin
					if (busy || m != want)
						report_fault($sformatf("master %0d AR accepted out of order", m));
					if (pend[m].tgt < 2) begin
						exp_ar                  = '0;
						exp_ar.id               = `AXI_IDS_BITS'(pend[m].id);
						exp_ar.id[`AXI_TAG_BIT] = m[0];   // Master index tag
						exp_ar.addr             = pend[m].addr;
						exp_ar.len              = pend[m].len;
						exp_ar.size             = AR_SIZE;
						exp_ar.burst            = AR_BURST;
						check_ar($sformatf("s%0d_ar", pend[m].tgt[0]), exp_ar,
							s_ar[pend[m].tgt[0]]);
					end
					m_ar_valid[m] <= 1'b0;
					pend_valid[m]  = 1'b0;
					busy = 1'b1;
					cur  = m;
					beat = 0;
				end
			end
			for (int k = 0; k < 2; k++) begin
				if (m_r_valid[k] && (!busy || k != cur)) begin
					report_fault($sformatf("master %0d got r_valid with no burst", k));
				end else if (m_r_valid[k] && m_r_ready[k]) begin
					exp_r.id   = pend[cur].id;
					exp_r.data = (pend[cur].tgt == 2) ? '0 : pend[cur].addr + 4 * beat;
					exp_r.resp = axi_pkg::resp_e'(pend[cur].resp[1:0]);
					exp_r.last = (beat == pend[cur].len);
					check_r($sformatf("m%0d_r", k), exp_r, m_r[k]);
					beat++;
					if (exp_r.last) begin
						busy        = 1'b0;
						last_served = cur[0];
					end
				end
				m_r_ready[k] <= ($urandom % 4) != 0;   // Random gaps
			end
		end
		if (pend_valid[0] || pend_valid[1] || busy) begin
			$display("%0t: timeout, a read burst did not complete", $time);
			timeouts++;
		end
	endtask

	// ---------------------------------------------------------------------------
	// Main sequence
	// ---------------------------------------------------------------------------
	initial begin
		req_t        r;
		int          idx;
		int          n;
		void'($urandom(32'h7353));
		mismatches    = 0;
		protocol_errs = 0;
		timeouts      = 0;
		last_served   = 1'b0;   // Master 1 wins first tie
		ARESETn       = 1'b0;
		for (int k = 0; k < 2; k++) begin
			m_ar[k]       = '0;
			m_ar_valid[k] = 1'b0;
			m_r_ready[k]  = 1'b0;
			s_ar_ready[k] = 1'b0;
			s_r[k]        = '0;
			s_r_valid[k]  = 1'b0;
			pend_valid[k] = 1'b0;
		end
		$readmemh("sim/xbar_input.txt", req_mem);
		repeat (5) @(posedge ACLK);
		for (int k = 0; k < 2; k++)
			if (m_ar_ready[k] || m_r_valid[k] || s_ar_valid[k] || s_r_ready[k])
				report_fault($sformatf("port %0d not idle in reset", k));
		ARESETn <= 1'b1;
		idx = 0;
		while (idx < MAX_REQS && !$isunknown(req_mem[idx]) && timeouts == 0) begin
			r = req_mem[idx];
			n = (r.pair != 0) ? 2 : 1;
			@(posedge ACLK);
			for (int j = 0; j < n; j++)
				issue_request(req_t'(req_mem[idx + j]), idx + j);
			idx += n;
			serve_pending();
		end
		$display("Mismatches %0d, protocol errors %0d, timeouts %0d",
			mismatches, protocol_errs, timeouts);
		if (mismatches + protocol_errs + timeouts == 0)
			$display("test passed");
		else
			$display("test failed");
		$finish;
	end

endmodule

// File: sim/xbar_input.txt
// Columns in hex: master_id_address_len_target_resp_pair
// target 0 slave 0, 1 slave 1, 2 unmapped; resp 0 OKAY, 3 DECERR; pair 1 issues with next line
0_3_00000100_3_0_0_1
1_5_00004200_2_1_0_0
0_1_00000040_0_0_0_0
1_a_00007ff0_7_1_0_0
0_2_00010000_2_2_3_0
1_f_00008000_0_2_3_0
0_4_00004000_1_1_0_1
1_6_00000800_4_0_0_0
1_7_0000c010_2_2_3_1
0_8_00003ffc_1_0_0_0
0_9_00004abc_f_1_0_0
0_c_12340000_1_2_3_1
1_d_ffff4000_3_2_3_0
1_0_00002000_1_0_0_0
1_e_00005000_5_1_0_1
0_b_00001234_2_0_0_0

// File: build.f
+incdir+rtl
rtl/axi_pkg.sv
rtl/xbar_map_pkg.sv
rtl/ar_arbiter.sv
rtl/ar_router.sv
rtl/r_return.sv
rtl/axi_read_xbar.sv
sim/axi_read_xbar_tb.sv
